// ==== files.f ====
design/core_pkg.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module core_tb -f files.f || exit 1
out=$(./obj_dir/Vcore_tb)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/core_tb.sv ====
/*
 * Random OP and OP-IMM stream against a reference model, fixed seed.
 * Results are checked in order and the run stops at the first mismatch.
 */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int N_SEED  = 31;
    localparam int N_RR    = 200;
    localparam int N_RI    = 200;
    localparam int N_CHAIN = 150;
    localparam int N_BAD   = 40;
    localparam int N_BP    = 300;
    // Each bad group issues three words, plus the first add after reset
    localparam int N_TOTAL = 1 + N_SEED + N_RR + N_RI + N_CHAIN + 3 * N_BAD + N_BP;
    localparam int TIMEOUT_CYCLES = 4 * N_TOTAL + 100;
    // Three items in flight drain well within this
    localparam int DRAIN_CYCLES = 20;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  instr_valid_i;
    instr_t                instr_i;
    logic                  instr_ready_o;
    logic                  res_valid_o;
    logic                  res_ready_i;
    logic [REG_ADDR_W-1:0] res_rd_o;
    logic [XLEN-1:0]       res_data_o;
    logic                  res_illegal_o;

    logic [XLEN-1:0]          model_regs [NUM_REGS];
    logic [XLEN+REG_ADDR_W:0] exp_q [$];
    logic [31:0]              rng;
    logic                     bp_on;
    int                       cycle_count = 0;

    core_top uut (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .instr_ready_o ( instr_ready_o ),
        .res_valid_o   ( res_valid_o   ),
        .res_ready_i   ( res_ready_i   ),
        .res_rd_o      ( res_rd_o      ),
        .res_data_o    ( res_data_o    ),
        .res_illegal_o ( res_illegal_o )
    );

    always #2 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic void reference_result(input instr_t w,
                                             ref logic [XLEN-1:0] regs [NUM_REGS],
                                             output logic [REG_ADDR_W-1:0] rd,
                                             output logic [XLEN-1:0] data,
                                             output logic illegal);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] val;
        logic            legal;
        a     = regs[w.r.rs1];
        b     = '0;
        legal = 1'b0;
        if (w.r.opcode == OPCODE_OP) begin
            b     = regs[w.r.rs2];
            legal = (w.r.funct7 == FUNCT7_BASE) || (w.r.funct7 == FUNCT7_ALT &&
                    (w.r.funct3 == FUNCT3_ADD_SUB || w.r.funct3 == FUNCT3_SRL_SRA));
        end else if (w.r.opcode == OPCODE_OP_IMM) begin
            b     = {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
            legal = 1'b1;
            if (w.r.funct3 == FUNCT3_SLL) begin
                legal = (w.r.funct7 == FUNCT7_BASE);
            end else if (w.r.funct3 == FUNCT3_SRL_SRA) begin
                legal = (w.r.funct7 == FUNCT7_BASE) || (w.r.funct7 == FUNCT7_ALT);
            end
        end
        case (w.r.funct3)
            FUNCT3_ADD_SUB: val = (w.r.opcode == OPCODE_OP && w.r.funct7[5]) ? a - b : a + b;
            FUNCT3_SLL:     val = a << b[4:0];
            FUNCT3_SLT:     val = {31'd0, $signed(a) < $signed(b)};
            FUNCT3_SLTU:    val = {31'd0, a < b};
            FUNCT3_XOR:     val = a ^ b;
            FUNCT3_SRL_SRA: begin
                if (w.r.funct7[5]) begin
                    val = $signed(a) >>> b[4:0];
                end else begin
                    val = a >> b[4:0];
                end
            end
            FUNCT3_OR:      val = a | b;
            default:        val = a & b;
        endcase
        illegal = !legal;
        rd      = legal ? w.r.rd : '0;
        data    = legal ? val : '0;
        // x0 stays zero
        if (legal && w.r.rd != '0) begin
            regs[w.r.rd] = val;
        end
    endfunction

    // ------------------------------
    // Word builders
    // ------------------------------
    function automatic instr_t make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_t w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = OPCODE_OP;
        return w;
    endfunction

    function automatic instr_t make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
        instr_t w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = OPCODE_OP_IMM;
        return w;
    endfunction

    function automatic instr_t rand_r(input logic [31:0] r);
        logic [6:0] f7;
        f7 = FUNCT7_BASE;
        if ((r[2:0] == FUNCT3_ADD_SUB || r[2:0] == FUNCT3_SRL_SRA) && r[3]) begin
            f7 = FUNCT7_ALT;
        end
        return make_r(f7, r[13:9], r[8:4], r[2:0], r[18:14]);
    endfunction

    function automatic instr_t rand_i(input logic [31:0] r);
        logic [11:0] imm;
        imm = r[31:20];
        // Shift immediates carry the form in the upper seven bits
        if (r[2:0] == FUNCT3_SLL) begin
            imm = {FUNCT7_BASE, r[24:20]};
        end else if (r[2:0] == FUNCT3_SRL_SRA) begin
            imm = {r[25] ? FUNCT7_ALT : FUNCT7_BASE, r[24:20]};
        end
        return make_i(imm, r[8:4], r[2:0], r[18:14]);
    endfunction

    // Holds the word until the DUT takes it
    // Back-pressure is redrawn every cycle
    task automatic issue(input instr_t w);
        logic taken;
        taken = 1'b0;
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        while (!taken) begin
            @(negedge clk_i);
            taken = instr_ready_o;
            @(posedge clk_i);
            rng = xorshift32(rng);
            res_ready_i <= bp_on ? (rng[1:0] != 2'b00) : 1'b1;
        end
    endtask

    // ------------------------------
    // Monitors
    // ------------------------------
    always @(negedge clk_i) begin
        logic [REG_ADDR_W-1:0] e_rd;
        logic [XLEN-1:0]       e_data;
        logic                  e_ill;
        if (rst_ni && instr_valid_i && instr_ready_o) begin
            reference_result(instr_i, model_regs, e_rd, e_data, e_ill);
            exp_q.push_back({e_ill, e_rd, e_data});
        end
    end

    always @(negedge clk_i) begin
        logic [XLEN+REG_ADDR_W:0] e;
        if (rst_ni && res_valid_o && res_ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("A result came out with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                assert (res_rd_o == e[XLEN+REG_ADDR_W-1:XLEN]) else abort_run($sformatf(
                    "** Error: res_rd_o = 0x%h, expected 0x%h",
                    res_rd_o, e[XLEN+REG_ADDR_W-1:XLEN]));
                assert (res_data_o == e[XLEN-1:0]) else abort_run($sformatf(
                    "** Error: res_data_o = 0x%h, expected 0x%h", res_data_o, e[XLEN-1:0]));
                assert (res_illegal_o == e[XLEN+REG_ADDR_W]) else abort_run($sformatf(
                    "** Error: res_illegal_o = 0x%h, expected 0x%h",
                    res_illegal_o, e[XLEN+REG_ADDR_W]));
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            abort_run("Timeout, the pipeline stopped delivering results");
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        instr_t     w;
        logic [4:0] prev_rd;
        int         drain_cycles;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        res_ready_i   = 1'b1;
        bp_on         = 1'b0;
        rng           = 32'd18387;
        for (int k = 0; k < NUM_REGS; k++) begin
            model_regs[k] = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (instr_ready_o == 1'b1) else abort_run($sformatf(
            "** Error: instr_ready_o = 0x%h after reset, expected 0x1", instr_ready_o));
        assert (res_valid_o == 1'b0) else abort_run($sformatf(
            "** Error: res_valid_o = 0x%h after reset, expected 0x0", res_valid_o));
        @(posedge clk_i);

        // Sources still zero
        issue(make_r(FUNCT7_BASE, 5'd7, 5'd3, FUNCT3_ADD_SUB, 5'd5));
        for (int k = 1; k <= N_SEED; k++) begin
            rng = xorshift32(rng);
            issue(make_i(rng[31:20], 5'd0, FUNCT3_ADD_SUB, 5'(k)));
        end
        for (int n = 0; n < N_RR; n++) begin
            rng = xorshift32(rng);
            issue(rand_r(rng));
        end
        for (int n = 0; n < N_RI; n++) begin
            rng = xorshift32(rng);
            issue(rand_i(rng));
        end

        // Dependent chain
        prev_rd = 5'd1;
        for (int n = 0; n < N_CHAIN; n++) begin
            rng = xorshift32(rng);
            w = rng[19] ? rand_r(rng) : rand_i(rng);
            w.r.rs1 = prev_rd;
            if (w.r.opcode == OPCODE_OP && rng[30]) begin
                w.r.rs2 = prev_rd;
            end
            if (w.r.rd == 5'd0) begin
                w.r.rd = 5'd1;
            end
            prev_rd = w.r.rd;
            issue(w);
        end

        // Bad encodings, then a dropped x0 write and a read of x0
        for (int n = 0; n < N_BAD; n++) begin
            rng = xorshift32(rng);
            w = rng;
            case (rng[1:0])
                2'd0: w.r.opcode[0] = 1'b0;
                2'd1: begin
                    w = rand_r(rng);
                    w.r.funct7[6] = 1'b1;
                end
                2'd2: w = make_i({FUNCT7_ALT, rng[24:20]}, rng[12:8], FUNCT3_SLL, rng[18:14]);
                default: w = make_r(FUNCT7_ALT, rng[8:4], rng[12:8], FUNCT3_XOR, rng[18:14]);
            endcase
            issue(w);
            issue(make_i(rng[31:20], rng[12:8], FUNCT3_ADD_SUB, 5'd0));
            issue(make_r(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_OR, rng[18:14]));
        end

        // Random back-pressure and input gaps
        bp_on = 1'b1;
        for (int n = 0; n < N_BP; n++) begin
            rng = xorshift32(rng);
            if (rng[22:20] == 3'd0) begin
                instr_valid_i <= 1'b0;
                @(posedge clk_i);
            end
            rng = xorshift32(rng);
            issue(rng[19] ? rand_r(rng) : rand_i(rng));
        end

        bp_on = 1'b0;
        instr_valid_i <= 1'b0;
        res_ready_i   <= 1'b1;
        drain_cycles = 0;
        while (exp_q.size() != 0 && drain_cycles < DRAIN_CYCLES) begin
            @(posedge clk_i);
            drain_cycles++;
        end
        // Quiet period catches any extra result
        repeat (10) @(posedge clk_i);
        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("Results were still missing at the end of the run");
        end
    end

endmodule

// ==== design/core_top.sv ====
/*
 * Decode, execute and result stages in a row, one item each.
 * Results leave in issue order on a valid/ready stream.
 */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  instr_valid_i,
    input  instr_t                instr_i,
    output logic                  instr_ready_o,
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [REG_ADDR_W-1:0] res_rd_o,
    output logic [XLEN-1:0]       res_data_o,
    output logic                  res_illegal_o
);

    // Decode to execute
    logic                  dec_valid;
    logic                  dec_ready;
    logic [ALU_OP_W-1:0]   dec_alu_op;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic                  dec_use_imm;
    logic [XLEN-1:0]       dec_imm;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic                  dec_illegal;

    // Execute to result
    logic                  exe_valid;
    logic                  exe_ready;
    logic [REG_ADDR_W-1:0] exe_rd;
    logic [XLEN-1:0]       exe_data;
    logic                  exe_illegal;

    // Register file read ports
    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic [XLEN-1:0]       rf_rdata_a;
    logic [XLEN-1:0]       rf_rdata_b;

    // ------------------------------
    // Stages
    // ------------------------------
    decode_stage u_decode (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .instr_ready_o ( instr_ready_o ),
        .dec_valid_o   ( dec_valid     ),
        .dec_ready_i   ( dec_ready     ),
        .dec_alu_op_o  ( dec_alu_op    ),
        .dec_rs1_o     ( dec_rs1       ),
        .dec_rs2_o     ( dec_rs2       ),
        .dec_use_imm_o ( dec_use_imm   ),
        .dec_imm_o     ( dec_imm       ),
        .dec_rd_o      ( dec_rd        ),
        .dec_illegal_o ( dec_illegal   )
    );

    execute_stage u_execute (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .dec_valid_i   ( dec_valid   ),
        .dec_ready_o   ( dec_ready   ),
        .dec_alu_op_i  ( dec_alu_op  ),
        .dec_rs1_i     ( dec_rs1     ),
        .dec_rs2_i     ( dec_rs2     ),
        .dec_use_imm_i ( dec_use_imm ),
        .dec_imm_i     ( dec_imm     ),
        .dec_rd_i      ( dec_rd      ),
        .dec_illegal_i ( dec_illegal ),
        .rf_raddr_a_o  ( rf_raddr_a  ),
        .rf_raddr_b_o  ( rf_raddr_b  ),
        .rf_rdata_a_i  ( rf_rdata_a  ),
        .rf_rdata_b_i  ( rf_rdata_b  ),
        .exe_valid_o   ( exe_valid   ),
        .exe_ready_i   ( exe_ready   ),
        .exe_rd_o      ( exe_rd      ),
        .exe_data_o    ( exe_data    ),
        .exe_illegal_o ( exe_illegal )
    );

    result_stage u_result (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .exe_valid_i   ( exe_valid     ),
        .exe_ready_o   ( exe_ready     ),
        .exe_rd_i      ( exe_rd        ),
        .exe_data_i    ( exe_data      ),
        .exe_illegal_i ( exe_illegal   ),
        .rf_raddr_a_i  ( rf_raddr_a    ),
        .rf_raddr_b_i  ( rf_raddr_b    ),
        .rf_rdata_a_o  ( rf_rdata_a    ),
        .rf_rdata_b_o  ( rf_rdata_b    ),
        .res_valid_o   ( res_valid_o   ),
        .res_ready_i   ( res_ready_i   ),
        .res_rd_o      ( res_rd_o      ),
        .res_data_o    ( res_data_o    ),
        .res_illegal_o ( res_illegal_o )
    );

endmodule

// ==== design/result_stage.sv ====
/*
 * Owns the 32-entry register file, x0 is never written and reads zero.
 * Write-back happens as an item enters this stage, not when it leaves.
 */
`timescale 1ns/1ps

module result_stage import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  exe_valid_i,
    output logic                  exe_ready_o,
    input  logic [REG_ADDR_W-1:0] exe_rd_i,
    input  logic [XLEN-1:0]       exe_data_i,
    input  logic                  exe_illegal_i,
    input  logic [REG_ADDR_W-1:0] rf_raddr_a_i,
    input  logic [REG_ADDR_W-1:0] rf_raddr_b_i,
    output logic [XLEN-1:0]       rf_rdata_a_o,
    output logic [XLEN-1:0]       rf_rdata_b_o,
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [REG_ADDR_W-1:0] res_rd_o,
    output logic [XLEN-1:0]       res_data_o,
    output logic                  res_illegal_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            accept;
    logic            rf_we;

    assign exe_ready_o = ~res_valid_o | res_ready_i;
    assign accept      = exe_valid_i && exe_ready_o;
    assign rf_we       = accept && !exe_illegal_i && (exe_rd_i != '0);

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (rf_we) begin
            regs[exe_rd_i] <= exe_data_i;
        end
    end

    // Asynchronous reads for the execute stage
    assign rf_rdata_a_o = regs[rf_raddr_a_i];
    assign rf_rdata_b_o = regs[rf_raddr_b_i];

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_o <= 1'b0;
        end else if (exe_ready_o) begin
            res_valid_o <= exe_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_rd_o      <= exe_rd_i;
            res_data_o    <= exe_data_i;
            res_illegal_o <= exe_illegal_i;
        end
    end

endmodule

// ==== design/execute_stage.sv ====
/*
 * Reads operands from the register file and bypasses its own held result.
 * Illegal items pass through with data zero.
 */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  dec_valid_i,
    output logic                  dec_ready_o,
    input  logic [ALU_OP_W-1:0]   dec_alu_op_i,
    input  logic [REG_ADDR_W-1:0] dec_rs1_i,
    input  logic [REG_ADDR_W-1:0] dec_rs2_i,
    input  logic                  dec_use_imm_i,
    input  logic [XLEN-1:0]       dec_imm_i,
    input  logic [REG_ADDR_W-1:0] dec_rd_i,
    input  logic                  dec_illegal_i,
    output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
    output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
    input  logic [XLEN-1:0]       rf_rdata_a_i,
    input  logic [XLEN-1:0]       rf_rdata_b_i,
    output logic                  exe_valid_o,
    input  logic                  exe_ready_i,
    output logic [REG_ADDR_W-1:0] exe_rd_o,
    output logic [XLEN-1:0]       exe_data_o,
    output logic                  exe_illegal_o
);

    logic            valid_q;
    logic            fwd_ok;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;

    assign rf_raddr_a_o = dec_rs1_i;
    assign rf_raddr_b_o = dec_rs2_i;

    // ------------------------------
    // Operands and bypass
    // ------------------------------
    // Held result is not in the register file yet
    assign fwd_ok  = valid_q && !exe_illegal_o && (exe_rd_o != '0);
    assign rs1_val = (fwd_ok && exe_rd_o == dec_rs1_i) ? exe_data_o : rf_rdata_a_i;
    assign rs2_val = (fwd_ok && exe_rd_o == dec_rs2_i) ? exe_data_o : rf_rdata_b_i;

    assign op_a  = rs1_val;
    assign op_b  = dec_use_imm_i ? dec_imm_i : rs2_val;
    assign shamt = op_b[4:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (dec_alu_op_i)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    assign dec_ready_o = ~valid_q | exe_ready_i;
    assign exe_valid_o = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (dec_ready_o) begin
            valid_q <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i && dec_ready_o) begin
            exe_rd_o      <= dec_rd_i;
            exe_data_o    <= dec_illegal_i ? '0 : alu_res;
            exe_illegal_o <= dec_illegal_i;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
/*
 * Decodes OP and OP-IMM words, anything else is flagged illegal with rd = x0.
 * One-entry stage, ready is combinational from the downstream ready.
 */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  instr_valid_i,
    input  instr_t                instr_i,
    output logic                  instr_ready_o,
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    output logic [ALU_OP_W-1:0]   dec_alu_op_o,
    output logic [REG_ADDR_W-1:0] dec_rs1_o,
    output logic [REG_ADDR_W-1:0] dec_rs2_o,
    output logic                  dec_use_imm_o,
    output logic [XLEN-1:0]       dec_imm_o,
    output logic [REG_ADDR_W-1:0] dec_rd_o,
    output logic                  dec_illegal_o
);

    logic [ALU_OP_W-1:0]   alu_op;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;
    logic                  illegal;
    logic                  alt;
    logic                  valid_q;

    assign alt = (instr_i.r.funct7 == FUNCT7_ALT);

    // ------------------------------
    // Field decode
    // ------------------------------
    always_comb begin
        alu_op  = ALU_ADD;
        rs2     = '0;
        rd      = instr_i.r.rd;
        use_imm = 1'b0;
        imm     = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
        illegal = 1'b0;

        case (instr_i.r.opcode)
            OPCODE_OP: begin
                rs2 = instr_i.r.rs2;
                case (instr_i.r.funct3)
                    FUNCT3_ADD_SUB: alu_op = alt ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLL:     alu_op = ALU_SLL;
                    FUNCT3_SLT:     alu_op = ALU_SLT;
                    FUNCT3_SLTU:    alu_op = ALU_SLTU;
                    FUNCT3_XOR:     alu_op = ALU_XOR;
                    FUNCT3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
                    FUNCT3_OR:      alu_op = ALU_OR;
                    default:        alu_op = ALU_AND;
                endcase
                // ALT is only meaningful for sub and sra
                if (instr_i.r.funct7 != FUNCT7_BASE &&
                    !(alt && (instr_i.r.funct3 == FUNCT3_ADD_SUB ||
                              instr_i.r.funct3 == FUNCT3_SRL_SRA))) begin
                    illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: begin
                use_imm = 1'b1;
                case (instr_i.i.funct3)
                    FUNCT3_ADD_SUB: alu_op = ALU_ADD;
                    FUNCT3_SLT:     alu_op = ALU_SLT;
                    FUNCT3_SLTU:    alu_op = ALU_SLTU;
                    FUNCT3_XOR:     alu_op = ALU_XOR;
                    FUNCT3_OR:      alu_op = ALU_OR;
                    FUNCT3_AND:     alu_op = ALU_AND;
                    FUNCT3_SLL: begin
                        alu_op  = ALU_SLL;
                        imm     = {{(XLEN-5){1'b0}}, instr_i.i.imm12[4:0]};
                        illegal = (instr_i.r.funct7 != FUNCT7_BASE);
                    end
                    default: begin
                        // srli / srai, upper bits hold the shift form
                        alu_op  = alt ? ALU_SRA : ALU_SRL;
                        imm     = {{(XLEN-5){1'b0}}, instr_i.i.imm12[4:0]};
                        illegal = !alt && (instr_i.r.funct7 != FUNCT7_BASE);
                    end
                endcase
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            rd = '0;
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    assign instr_ready_o = ~valid_q | dec_ready_i;
    assign dec_valid_o   = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (instr_ready_o) begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i && instr_ready_o) begin
            dec_alu_op_o  <= alu_op;
            dec_rs1_o     <= instr_i.r.rs1;
            dec_rs2_o     <= rs2;
            dec_use_imm_o <= use_imm;
            dec_imm_o     <= imm;
            dec_rd_o      <= rd;
            dec_illegal_o <= illegal;
        end
    end

endmodule

// ==== design/core_pkg.sv ====
/*
 * Shared widths and encodings for the RV32I integer subset (OP and OP-IMM only).
 * No loads, stores, branches or CSRs are decoded.
 */
package core_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // Function codes shared by both formats
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Upper function field, ALT picks sub and sra
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // ------------------------------
    // ALU operations
    // ------------------------------
    localparam int unsigned ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    // ------------------------------
    // Instruction word
    // ------------------------------
    // Same 32 bits, read as R-type or I-type depending on the opcode
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } instr_t;

endpackage
